//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --assert -j 0
TOP       := tb_cast_unit
FILELIST  := all.f
OBJ_DIR   := obj_dir
SIM       := $(OBJ_DIR)/V$(TOP)
SOURCES   := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

$(SIM): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; \
	echo "$$out" | grep -qx "Finished with no errors"

clean:
	rm -rf $(OBJ_DIR)

//--- all.f
common/cast_pkg.sv
hw/cast_pipe_reg.sv
hw/cast_decode/cast_decode.sv
hw/cast_round/cast_align.sv
hw/cast_round/cast_round.sv
hw/cast_unit.sv
test/cast_unit_asserts.sv
test/tb_cast_unit.sv

//--- common/cast_pkg.sv
// --------------------------------------
// Shared widths, encodings and payload structs for the float/int cast unit
// Every stage imports this package by wildcard in its module header
// --------------------------------------

package cast_pkg;

  // --------------------------------------
  // Widths and format constants
  // --------------------------------------
  localparam int WORD_W   = 32;  // Operand and result width
  localparam int EXP_BITS = 8;   // binary32 exponent field
  localparam int MAN_BITS = 23;  // binary32 fraction field
  localparam int FP_BIAS  = 127; // binary32 exponent bias
  localparam int EXP_W    = 10;  // Internal signed exponent, covers subnormals
  localparam int LZC_W    = 5;   // Leading-zero count over one word

  // Meaningful vector widths
  typedef logic [WORD_W-1:0]       word_t;  // Operand, result or integer magnitude
  typedef logic signed [EXP_W-1:0] exp_t;   // Unbiased true exponent
  typedef logic [5:0]              shamt_t; // Alignment shift, up to WORD_W+1

  // --------------------------------------
  // Encodings
  // --------------------------------------
  typedef enum logic {
    OP_F2I = 1'b0, // binary32 to int32
    OP_I2F = 1'b1  // int32 to binary32
  } cast_op_e;

  // RISC-V rounding mode encoding
  typedef enum logic [2:0] {
    RNE = 3'b000, // Nearest, ties to even
    RTZ = 3'b001, // Toward zero
    RDN = 3'b010, // Toward minus infinity
    RUP = 3'b011, // Toward plus infinity
    RMM = 3'b100  // Nearest, ties away from zero
  } rnd_mode_e;

  // Exception flags kept by this unit
  typedef struct packed {
    logic nv; // Invalid operation
    logic nx; // Inexact
  } status_t;

  // --------------------------------------
  // Pipeline payloads
  // --------------------------------------
  // Input request as presented at the top ports
  typedef struct packed {
    word_t     operand;
    cast_op_e  op;
    logic      op_mod;   // 1 selects unsigned integer
    rnd_mode_e rnd_mode;
  } cast_req_t;

  // Decoded operand, mantissa normalized with its leading one at bit 31
  typedef struct packed {
    logic      sign;
    exp_t      exp;      // Weight of mant[31] is 2**exp
    word_t     mant;
    logic      is_zero;
    logic      is_nan;   // Quiet NaN
    logic      is_snan;  // Signalling NaN
    logic      is_inf;
    cast_op_e  op;
    logic      op_mod;
    rnd_mode_e rnd_mode;
  } cast_norm_t;

  // Aligned value ready for rounding, combinational link only
  typedef struct packed {
    logic       sign;
    word_t      abs_value;       // Integer, or exponent and fraction for I2F
    logic [1:0] round_sticky;    // {round, sticky}
    logic       of_before_round; // Integer range already exceeded
    logic       is_nan;          // Either NaN kind
    logic       is_inf;
    cast_op_e   op;
    logic       op_mod;
    rnd_mode_e  rnd_mode;
  } cast_aligned_t;

  // Final result and flags
  typedef struct packed {
    word_t   result;
    status_t status;
  } cast_res_t;

endpackage

//--- hw/cast_decode/cast_decode.sv
// --------------------------------------
// Decode stage: classifies the float or takes the integer magnitude,
// then normalizes the mantissa by a leading-zero count
// --------------------------------------

`timescale 1ns/1ps

module cast_decode import cast_pkg::*; (
  input  cast_req_t  req_i,
  output cast_norm_t norm_o
);

  logic                is_i2f;
  // Float fields
  logic [EXP_BITS-1:0] fp_exp;
  logic [MAN_BITS-1:0] fp_frac;
  logic                fp_exp_max;  // All ones, inf or NaN
  logic                fp_exp_zero; // Zero or subnormal
  logic                fp_is_sub;
  word_t               fp_mant;     // Implicit bit at MAN_BITS
  // Integer path
  logic                int_sign;
  word_t               int_mag;
  // Normalization
  word_t               enc_mant;
  logic [LZC_W-1:0]    lz_cnt;
  logic                mant_zero;
  exp_t                fp_true_exp;
  exp_t                int_true_exp;

  assign is_i2f = (req_i.op == OP_I2F);

  // --------------------------------------
  // Float operand split
  // --------------------------------------
  assign fp_exp      = req_i.operand[WORD_W-2 -: EXP_BITS];
  assign fp_frac     = req_i.operand[MAN_BITS-1:0];
  assign fp_exp_max  = &fp_exp;
  assign fp_exp_zero = ~|fp_exp;
  assign fp_is_sub   = fp_exp_zero & (|fp_frac); // Exponent acts as 1
  // Zero pad above the implicit bit
  assign fp_mant     = {{(WORD_W-MAN_BITS-1){1'b0}}, ~fp_exp_zero, fp_frac};

  // --------------------------------------
  // Integer operand
  // --------------------------------------
  assign int_sign = req_i.operand[WORD_W-1] & ~req_i.op_mod; // Unsigned is never negative
  assign int_mag  = int_sign ? word_t'(-req_i.operand) : req_i.operand;

  assign enc_mant = is_i2f ? int_mag : fp_mant;

  // Leading-zero count, highest set bit wins
  always_comb begin : lzc
    lz_cnt    = '0;
    mant_zero = 1'b1;
    for (int i = 0; i < WORD_W; i++) begin
      if (enc_mant[i]) begin
        lz_cnt    = LZC_W'(WORD_W - 1 - i);
        mant_zero = 1'b0;
      end
    end
  end

  // Unbias and compensate for the normalizing shift
  assign fp_true_exp  = exp_t'(int'(fp_exp) + int'(fp_is_sub) - FP_BIAS
                               - int'(lz_cnt) + (WORD_W - 1 - MAN_BITS));
  assign int_true_exp = exp_t'(WORD_W - 1 - int'(lz_cnt)); // Integer LSB has weight 1

  // --------------------------------------
  // Decoded payload
  // --------------------------------------
  always_comb begin : pack_norm
    norm_o.sign     = is_i2f ? int_sign : req_i.operand[WORD_W-1];
    norm_o.exp      = is_i2f ? int_true_exp : fp_true_exp;
    norm_o.mant     = enc_mant << lz_cnt;     // Leading one to the MSB
    norm_o.is_zero  = mant_zero;              // Also catches integer zero
    // Float classes only mean something for F2I
    norm_o.is_inf   = ~is_i2f & fp_exp_max & ~|fp_frac;
    norm_o.is_nan   = ~is_i2f & fp_exp_max & fp_frac[MAN_BITS-1];
    norm_o.is_snan  = ~is_i2f & fp_exp_max & ~fp_frac[MAN_BITS-1] & (|fp_frac);
    norm_o.op       = req_i.op;
    norm_o.op_mod   = req_i.op_mod;
    norm_o.rnd_mode = req_i.rnd_mode;
  end

endmodule

//--- hw/cast_pipe_reg.sv
// --------------------------------------
// One elastic pipeline stage with valid/ready handshake and flush
// Payload type is set per instance, used for all three cast stages
// --------------------------------------

`timescale 1ns/1ps

module cast_pipe_reg import cast_pkg::*; #(
  parameter type payload_t = cast_req_t
) (
  input  logic     clk_i,
  input  logic     reset_i,
  input  logic     flush_i,   // Drops the item held here
  // Upstream side
  input  logic     valid_i,
  output logic     ready_o,
  input  payload_t data_i,
  // Downstream side
  output logic     valid_o,
  input  logic     ready_i,
  output payload_t data_o
);

  logic     valid_q;
  payload_t data_q;

  // Accept when downstream takes our item or we only hold a bubble
  assign ready_o = ready_i | ~valid_q;

  // Valid bit, flush wins over a new load
  always_ff @(posedge clk_i) begin
    if (reset_i || flush_i) begin
      valid_q <= 1'b0;
    end else if (ready_o) begin
      valid_q <= valid_i;
    end
  end

  // Payload only moves with a real item
  always_ff @(posedge clk_i) begin
    if (valid_i && ready_o) begin
      data_q <= data_i;
    end
  end

  assign valid_o = valid_q;
  assign data_o  = data_q; // Held stable while stalled

endmodule

//--- hw/cast_round/cast_align.sv
// --------------------------------------
// Align stage: moves the normalized mantissa into integer or float
// position and collapses the dropped bits into round and sticky
// --------------------------------------

`timescale 1ns/1ps

module cast_align import cast_pkg::*; (
  input  cast_norm_t    norm_i,
  output cast_aligned_t aligned_o
);

  logic                is_f2i;
  int                  exp_val;    // Signed exponent for compares
  // Integer path
  shamt_t              f2i_shamt;
  logic                f2i_of;
  logic [2*WORD_W-1:0] shifted;    // Integer on top, lost bits below
  logic [1:0]          int_rs;
  // Float path
  logic [EXP_BITS-1:0] biased_exp;
  word_t               fp_abs;
  logic [1:0]          fp_rs;

  assign is_f2i  = (norm_i.op == OP_F2I);
  assign exp_val = int'($signed(norm_i.exp));

  // --------------------------------------
  // F2I shift amount and early overflow
  // --------------------------------------
  always_comb begin : f2i_shift
    f2i_of    = 1'b0;
    f2i_shamt = shamt_t'(WORD_W - 1 - exp_val); // Land the integer LSB at bit WORD_W
    // Unsigned range is one bit wider
    if (exp_val >= WORD_W - 1 + int'(norm_i.op_mod)) begin
      f2i_shamt = '0;
      f2i_of    = 1'b1;
    end else if (exp_val < -1) begin
      f2i_shamt = shamt_t'(WORD_W + 1); // Below half, all into sticky
    end
  end

  assign shifted = {norm_i.mant, {WORD_W{1'b0}}} >> f2i_shamt;
  assign int_rs  = {shifted[WORD_W-1], |shifted[WORD_W-2:0]};

  // --------------------------------------
  // I2F packing, top 24 bits kept
  // --------------------------------------
  assign biased_exp = EXP_BITS'(exp_val + FP_BIAS);

  always_comb begin : i2f_pack
    fp_abs = {1'b0, biased_exp, norm_i.mant[WORD_W-2 -: MAN_BITS]}; // Drop the leading one
    fp_rs  = {norm_i.mant[WORD_W-2-MAN_BITS], |norm_i.mant[WORD_W-3-MAN_BITS:0]};
    if (norm_i.is_zero) begin
      fp_abs = '0; // Integer zero maps to +0.0
      fp_rs  = '0;
    end
  end

  // --------------------------------------
  // Output to rounding
  // --------------------------------------
  always_comb begin : pack_aligned
    aligned_o.sign            = norm_i.sign;
    aligned_o.abs_value       = is_f2i ? shifted[2*WORD_W-1:WORD_W] : fp_abs;
    aligned_o.round_sticky    = is_f2i ? int_rs : fp_rs;
    aligned_o.of_before_round = is_f2i & f2i_of;
    aligned_o.is_nan          = norm_i.is_nan | norm_i.is_snan; // Both saturate alike
    aligned_o.is_inf          = norm_i.is_inf;
    aligned_o.op              = norm_i.op;
    aligned_o.op_mod          = norm_i.op_mod;
    aligned_o.rnd_mode        = norm_i.rnd_mode;
  end

endmodule

//--- hw/cast_round/cast_round.sv
// --------------------------------------
// Round stage: applies the rounding mode, handles F2I saturation
// and builds the final result with its NV and NX flags
// --------------------------------------

`timescale 1ns/1ps

module cast_round import cast_pkg::*; (
  input  cast_aligned_t aligned_i,
  output cast_res_t     res_o
);

  logic            is_f2i;
  logic            sign;
  logic [1:0]      rs;          // {round, sticky}
  logic            inexact;
  logic            round_up;
  logic [WORD_W:0] rounded;     // Extra bit catches unsigned wrap
  word_t           int_res;
  logic            range_err;
  logic            neg_unsigned;
  logic            int_special;
  word_t           sat_value;

  assign is_f2i  = (aligned_i.op == OP_F2I);
  assign sign    = aligned_i.sign;
  assign rs      = aligned_i.round_sticky;
  assign inexact = |rs;

  // --------------------------------------
  // Rounding decision
  // --------------------------------------
  always_comb begin : rnd_decide
    case (aligned_i.rnd_mode)
      RNE:     round_up = rs[1] & (rs[0] | aligned_i.abs_value[0]); // Tie goes to even
      RTZ:     round_up = 1'b0;
      RDN:     round_up = inexact & sign;
      RUP:     round_up = inexact & ~sign;
      RMM:     round_up = rs[1];
      default: round_up = 1'b0;
    endcase
  end

  // One ulp up, an I2F fraction carry rolls into the exponent
  assign rounded = {1'b0, aligned_i.abs_value} + (WORD_W+1)'(round_up);

  // --------------------------------------
  // F2I result and special cases
  // --------------------------------------
  assign int_res = sign ? word_t'(-rounded[WORD_W-1:0]) : rounded[WORD_W-1:0];

  // Signed limit is 7FFFFFFF up, 80000000 down
  assign range_err    = aligned_i.op_mod ? rounded[WORD_W]
                                         : (rounded > {1'b0, sign, {(WORD_W-1){~sign}}});
  assign neg_unsigned = sign & aligned_i.op_mod & (|rounded);
  assign int_special  = aligned_i.is_nan | aligned_i.is_inf | aligned_i.of_before_round |
                        range_err | neg_unsigned;

  // Max positive by default, inverted for negatives except NaN
  always_comb begin : sat_pick
    sat_value = {aligned_i.op_mod, {(WORD_W-1){1'b1}}};
    if (sign && !aligned_i.is_nan) begin
      sat_value = ~sat_value;
    end
  end

  // --------------------------------------
  // Result select
  // --------------------------------------
  always_comb begin : res_pick
    if (is_f2i) begin
      if (int_special) begin
        res_o.result    = sat_value;
        res_o.status.nv = 1'b1; // Range errors report as invalid only
        res_o.status.nx = 1'b0;
      end else begin
        res_o.result    = int_res;
        res_o.status.nv = 1'b0;
        res_o.status.nx = inexact;
      end
    end else begin
      // I2F cannot overflow, sign goes on top
      res_o.result    = {sign, rounded[WORD_W-2:0]};
      res_o.status.nv = 1'b0;
      res_o.status.nx = inexact;
    end
  end

endmodule

//--- hw/cast_unit.sv
// --------------------------------------
// Top of the binary32/int32 cast unit, three register stages deep
// Inputs are taken with valid/ready, results leave the same way
// --------------------------------------

`timescale 1ns/1ps

module cast_unit import cast_pkg::*; (
  input  logic      clk_i,
  input  logic      reset_i,
  input  logic      flush_i,
  // Request
  input  word_t     operand_i,
  input  cast_op_e  op_i,
  input  logic      op_mod_i,    // 1 for unsigned integer
  input  rnd_mode_e rnd_mode_i,
  input  logic      in_valid_i,
  output logic      in_ready_o,
  // Response
  output word_t     result_o,
  output status_t   status_o,
  output logic      out_valid_o,
  input  logic      out_ready_i,
  output logic      busy_o       // Any item in flight
);

  cast_req_t     req_d, req_q;
  cast_norm_t    norm_d, norm_q;
  cast_aligned_t aligned;
  cast_res_t     res_d, res_q;
  logic          valid_in_q, valid_mid_q;
  logic          ready_mid, ready_out;

  assign req_d = '{operand: operand_i, op: op_i, op_mod: op_mod_i, rnd_mode: rnd_mode_i};

  // --------------------------------------
  // Stage 1, input register then decode
  // --------------------------------------
  cast_pipe_reg #(.payload_t(cast_req_t)) u_reg_in (
    .clk_i, .reset_i, .flush_i,
    .valid_i(in_valid_i), .ready_o(in_ready_o), .data_i(req_d),
    .valid_o(valid_in_q), .ready_i(ready_mid),  .data_o(req_q)
  );

  cast_decode u_decode (.req_i(req_q), .norm_o(norm_d));

  // Stage 2, decoded operand then align and round
  cast_pipe_reg #(.payload_t(cast_norm_t)) u_reg_mid (
    .clk_i, .reset_i, .flush_i,
    .valid_i(valid_in_q),  .ready_o(ready_mid), .data_i(norm_d),
    .valid_o(valid_mid_q), .ready_i(ready_out), .data_o(norm_q)
  );

  cast_align u_align (.norm_i(norm_q), .aligned_o(aligned));
  cast_round u_round (.aligned_i(aligned), .res_o(res_d));

  // Stage 3, output register drives the ports
  cast_pipe_reg #(.payload_t(cast_res_t)) u_reg_out (
    .clk_i, .reset_i, .flush_i,
    .valid_i(valid_mid_q), .ready_o(ready_out),   .data_i(res_d),
    .valid_o(out_valid_o), .ready_i(out_ready_i), .data_o(res_q)
  );

  assign result_o = res_q.result;
  assign status_o = res_q.status;
  assign busy_o   = valid_in_q | valid_mid_q | out_valid_o;

endmodule

//--- test/cast_unit_asserts.sv
// --------------------------------------
// Concurrent checks on the cast unit handshake, flush and flags
// Bound into every cast_unit instance
// --------------------------------------

`timescale 1ns/1ps

module cast_unit_asserts import cast_pkg::*; (
  input logic    clk_i,
  input logic    reset_i,
  input logic    flush_i,
  input logic    in_valid_i,
  input logic    in_ready_o,
  input word_t   result_o,
  input status_t status_o,
  input logic    out_valid_o,
  input logic    out_ready_i,
  input logic    busy_o
);

  int fail_cnt = 0; // Failed assertions so far

  // Stalled output holds its value
  a_stall_stable: assert property (@(posedge clk_i) disable iff (reset_i)
    out_valid_o && !out_ready_i && !flush_i |=>
      out_valid_o && $stable(result_o) && $stable(status_o))
    else begin
      $error("output changed while stalled");
      fail_cnt++;
    end

  // An accepted request is in flight on the next edge
  a_busy: assert property (@(posedge clk_i) disable iff (reset_i)
    in_valid_i && in_ready_o && !flush_i |=> busy_o)
    else begin
      $error("busy_o low after a request was accepted");
      fail_cnt++;
    end

  // NV only comes with a saturation value and never with NX
  a_flags: assert property (@(posedge clk_i) disable iff (reset_i)
    out_valid_o && status_o.nv |->
      !status_o.nx &&
      (result_o inside {32'h7FFF_FFFF, 32'h8000_0000, 32'hFFFF_FFFF, 32'h0000_0000}))
    else begin
      $error("NV set together with NX or with a non-saturated result");
      fail_cnt++;
    end

  // Flush empties every stage on the next edge
  a_flush: assert property (@(posedge clk_i) disable iff (reset_i)
    flush_i |=> !out_valid_o && !busy_o)
    else begin
      $error("out_valid_o or busy_o high right after flush");
      fail_cnt++;
    end

endmodule

bind cast_unit cast_unit_asserts u_asserts (.*);

//--- test/tb_cast_unit.sv
// --------------------------------------
// Testbench for the cast unit, runs a hand-worked table of F2I and I2F cases
// with out_ready held high, then under random stalls, then across a flush
// --------------------------------------

`timescale 1ns/1ps

module tb_cast_unit import cast_pkg::*;;

  localparam int N_VEC          = 21;
  localparam int TIMEOUT_CYCLES = N_VEC * 8 + 200;
  localparam int READY_HIGH     = 0;
  localparam int READY_RAND     = 1;
  localparam int READY_LOW      = 2;
  localparam status_t ST_OK = 2'b00;
  localparam status_t ST_NX = 2'b01;
  localparam status_t ST_NV = 2'b10;

  typedef struct packed {
    word_t     operand;
    cast_op_e  op;
    logic      op_mod;
    rnd_mode_e rnd;
    word_t     result;  // Expected
    status_t   status;  // Expected
  } vec_t;

  logic clk_i, reset_i, flush_i, op_mod_i, in_valid_i, in_ready_o;
  logic out_valid_o, out_ready_i, busy_o;
  word_t operand_i, result_o;
  cast_op_e op_i;
  rnd_mode_e rnd_mode_i;
  status_t status_o;

  vec_t  vec [N_VEC];
  string names [N_VEC];
  int    n_set, cur_idx, cycle, passed, failed, other_errs, accepted, received, dropped;
  int    pend_idx[$];  // Table index of each item in flight
  int    pend_cyc[$];  // Cycle it was accepted
  bit    check_latency;
  string phase;
  int    seed;

  cast_unit u_cast_unit (
    .clk_i, .reset_i, .flush_i, .operand_i, .op_i, .op_mod_i, .rnd_mode_i,
    .in_valid_i, .in_ready_o, .result_o, .status_o, .out_valid_o, .out_ready_i, .busy_o
  );

  initial begin
    clk_i = 1'b0;
    forever #50 clk_i = ~clk_i;
  end

  task automatic set_entry(input string name, input word_t opd, input cast_op_e op,
                           input logic md, input rnd_mode_e rnd, input word_t res,
                           input status_t st);
    vec[n_set]   = '{operand: opd, op: op, op_mod: md, rnd: rnd, result: res, status: st};
    names[n_set] = name;
    n_set++;
  endtask

  // Expected values worked out by hand from the binary32 encoding
  task automatic load_table();
    n_set = 0;
    set_entry("f2i 2.5 rne",       32'h4020_0000, OP_F2I, 1'b0, RNE, 32'h0000_0002, ST_NX);
    set_entry("f2i 2.5 rtz",       32'h4020_0000, OP_F2I, 1'b0, RTZ, 32'h0000_0002, ST_NX);
    set_entry("f2i 2.5 rdn",       32'h4020_0000, OP_F2I, 1'b0, RDN, 32'h0000_0002, ST_NX);
    set_entry("f2i 2.5 rup",       32'h4020_0000, OP_F2I, 1'b0, RUP, 32'h0000_0003, ST_NX);
    set_entry("f2i 2.5 rmm",       32'h4020_0000, OP_F2I, 1'b0, RMM, 32'h0000_0003, ST_NX);
    set_entry("f2i -2.5 rne",      32'hC020_0000, OP_F2I, 1'b0, RNE, 32'hFFFF_FFFE, ST_NX);
    set_entry("f2i -2.5 rdn",      32'hC020_0000, OP_F2I, 1'b0, RDN, 32'hFFFF_FFFD, ST_NX);
    set_entry("f2i 7.0",           32'h40E0_0000, OP_F2I, 1'b0, RNE, 32'h0000_0007, ST_OK);
    set_entry("f2i qnan",          32'h7FC0_0000, OP_F2I, 1'b0, RNE, 32'h7FFF_FFFF, ST_NV);
    set_entry("f2i -inf signed",   32'hFF80_0000, OP_F2I, 1'b0, RNE, 32'h8000_0000, ST_NV);
    set_entry("f2i 3e9 signed",    32'h4F32_D05E, OP_F2I, 1'b0, RNE, 32'h7FFF_FFFF, ST_NV);
    set_entry("f2i -1.0 unsigned", 32'hBF80_0000, OP_F2I, 1'b1, RNE, 32'h0000_0000, ST_NV);
    set_entry("f2i -0.25 uns rtz", 32'hBE80_0000, OP_F2I, 1'b1, RTZ, 32'h0000_0000, ST_NX);
    set_entry("f2i 2^31 unsigned", 32'h4F00_0000, OP_F2I, 1'b1, RNE, 32'h8000_0000, ST_OK);
    set_entry("i2f 1",             32'h0000_0001, OP_I2F, 1'b0, RNE, 32'h3F80_0000, ST_OK);
    set_entry("i2f -1 signed",     32'hFFFF_FFFF, OP_I2F, 1'b0, RNE, 32'hBF80_0000, ST_OK);
    set_entry("i2f 0",             32'h0000_0000, OP_I2F, 1'b0, RNE, 32'h0000_0000, ST_OK);
    set_entry("i2f -5 signed",     32'hFFFF_FFFB, OP_I2F, 1'b0, RNE, 32'hC0A0_0000, ST_OK);
    set_entry("i2f 7fffffff rne",  32'h7FFF_FFFF, OP_I2F, 1'b0, RNE, 32'h4F00_0000, ST_NX);
    set_entry("i2f ffffffff u rne", 32'hFFFF_FFFF, OP_I2F, 1'b1, RNE, 32'h4F80_0000, ST_NX);
    set_entry("i2f ffffffff u rtz", 32'hFFFF_FFFF, OP_I2F, 1'b1, RTZ, 32'h4F7F_FFFF, ST_NX);
  endtask

  function automatic logic next_ready(input int mode);
    logic r;
    case (mode)
      READY_HIGH: r = 1'b1;
      READY_LOW:  r = 1'b0;
      default:    r = (($random(seed) & 3) != 0); // Ready three times in four
    endcase
    return r;
  endfunction

  // --------------------------------------
  // Driver side
  // --------------------------------------
  task automatic send_entries(input int first, input int count, input int mode);
    int idx;
    idx = first;
    while (idx < first + count) begin
      @(negedge clk_i);
      operand_i   = vec[idx].operand;
      op_i        = vec[idx].op;
      op_mod_i    = vec[idx].op_mod;
      rnd_mode_i  = vec[idx].rnd;
      in_valid_i  = 1'b1;
      cur_idx     = idx;
      out_ready_i = next_ready(mode);
      @(posedge clk_i);
      if (in_ready_o) begin
        idx++; // Taken on this edge
      end
    end
    @(negedge clk_i);
    in_valid_i  = 1'b0;
    out_ready_i = next_ready(mode);
  endtask

  task automatic wait_drain(input int mode);
    while (pend_idx.size() != 0) begin
      @(negedge clk_i);
      out_ready_i = next_ready(mode);
    end
  endtask

  // Empty pipe, nothing valid and input side open
  task automatic check_idle(input string what);
    bit ok;
    ok = 1'b1;
    if (out_valid_o !== 1'b0) begin
      $display("FAIL %s: out_valid_o got %h expected 0", what, out_valid_o);
      ok = 1'b0;
    end
    if (busy_o !== 1'b0) begin
      $display("FAIL %s: busy_o got %h expected 0", what, busy_o);
      ok = 1'b0;
    end
    if (in_ready_o !== 1'b1) begin
      $display("FAIL %s: in_ready_o got %h expected 1", what, in_ready_o);
      ok = 1'b0;
    end
    if (ok) passed++;
    else failed++;
    $display("%-6s %-20s %s", "idle", what, ok ? "pass" : "failed");
  endtask

  // --------------------------------------
  // Receive side, in order against the table
  // --------------------------------------
  task automatic check_output();
    int idx;
    int acc;
    bit ok;
    if (pend_idx.size() == 0) begin
      $display("Output seen at cycle %0d with no request in flight", cycle);
      other_errs++;
    end else begin
      idx = pend_idx.pop_front();
      acc = pend_cyc.pop_front();
      ok  = 1'b1;
      if (result_o !== vec[idx].result) begin
        $display("FAIL %s: result_o got %h expected %h", names[idx], result_o, vec[idx].result);
        ok = 1'b0;
      end
      if (status_o !== vec[idx].status) begin
        $display("FAIL %s: status_o got %h expected %h", names[idx], status_o, vec[idx].status);
        ok = 1'b0;
      end
      if (check_latency && (cycle - acc != 3)) begin
        $display("%s came out %0d cycles after acceptance, not 3", names[idx], cycle - acc);
        ok = 1'b0;
      end
      received++;
      if (ok) passed++;
      else failed++;
      $display("%-6s %-20s %s", phase, names[idx], ok ? "pass" : "failed");
    end
  endtask

  always @(posedge clk_i) begin
    cycle++;
    if (!reset_i) begin
      if (flush_i) begin
        dropped += pend_idx.size(); // Items in flight are discarded
        pend_idx.delete();
        pend_cyc.delete();
      end else begin
        if (out_valid_o && out_ready_i) check_output();
        if (in_valid_i && in_ready_o) begin
          pend_idx.push_back(cur_idx);
          pend_cyc.push_back(cycle);
          accepted++;
        end
      end
    end
  end

  initial begin : watchdog
    int wd_cycles;
    wd_cycles = 0;
    while (wd_cycles < TIMEOUT_CYCLES) begin
      @(posedge clk_i);
      wd_cycles++;
    end
    $display("Timeout, run did not complete within %0d cycles", TIMEOUT_CYCLES);
    $display("Finished with errors");
    $finish;
  end

  initial begin : main
    seed        = 32'hbe8f_24d9;
    reset_i     = 1'b1;
    flush_i     = 1'b0;
    operand_i   = '0;
    op_i        = OP_F2I;
    op_mod_i    = 1'b0;
    rnd_mode_i  = RNE;
    in_valid_i  = 1'b0;
    out_ready_i = 1'b1;
    load_table();
    repeat (16) @(posedge clk_i);
    @(negedge clk_i);
    reset_i = 1'b0;
    @(negedge clk_i);
    check_idle("after reset");
    // Full rate, fixed latency
    phase         = "fixed";
    check_latency = 1'b1;
    send_entries(0, N_VEC, READY_HIGH);
    wait_drain(READY_HIGH);
    // Random back-pressure
    phase         = "stall";
    check_latency = 1'b0;
    send_entries(0, N_VEC, READY_RAND);
    wait_drain(READY_RAND);
    // Fill all three stages then flush them
    phase = "flush";
    send_entries(0, 3, READY_LOW);
    flush_i = 1'b1;
    @(negedge clk_i);
    flush_i = 1'b0;
    check_idle("after flush");
    send_entries(3, 5, READY_HIGH);
    wait_drain(READY_HIGH);
    if (accepted != received + dropped) begin
      $display("Lost or duplicated outputs: %0d accepted, %0d received, %0d flushed",
               accepted, received, dropped);
      other_errs++;
    end
    if (u_cast_unit.u_asserts.fail_cnt != 0) begin
      $display("Concurrent assertions failed %0d times", u_cast_unit.u_asserts.fail_cnt);
      other_errs += u_cast_unit.u_asserts.fail_cnt;
    end
    $display("Summary: %0d passed, %0d failed, %0d other errors", passed, failed, other_errs);
    if (failed == 0 && other_errs == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule
